// ==== tb.f ====
src/stream_pkg.sv
src/merge_pkg.sv
src/axis_upsizer.sv
src/packet_merge.sv
src/dual_upsize_merge.sv
verif/merge_assert.sv
verif/tb_dual_upsize_merge.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP      = tb_dual_upsize_merge
FILELIST = tb.f
OBJ_DIR  = obj_dir
EXE      = $(OBJ_DIR)/V$(TOP)
PASS_MSG = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(shell cat $(FILELIST))
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the pipeline status is the status of grep.
run: compile
	./$(EXE) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_dual_upsize_merge.sv ====
module tb_dual_upsize_merge;
  timeunit 1ns;
  timeprecision 100ps;
  import stream_pkg::*;
  import merge_pkg::*;

  localparam int num_packets = 40;
  localparam int max_len     = 13;
  localparam int period      = 10;
  // 80 packets of at most 13 bytes, 4 cycles per byte, plus reset.
  localparam int limit_ns = num_sources * num_packets * max_len * 4 * period + 8 * period;

  logic         clk;
  logic         rst;
  narrow_beat_t beat_drv [num_sources];
  logic         valid_drv [num_sources];
  logic         took_q [num_sources];
  logic         a_ready;
  logic         b_ready;
  merged_beat_t out_beat;
  logic         out_valid;
  logic         out_ready;

  narrow_beat_t stim_q [num_sources][$];
  int           gap_q [num_sources][$];
  narrow_beat_t exp_q [num_sources][$];  // bytes still owed per source.
  int           seed;
  int           err_cnt;
  int           beat_cnt;

  dual_upsize_merge dual_upsize_merge_i (
    .clk       (clk),
    .rst       (rst),
    .a_beat    (beat_drv[0]),
    .a_valid   (valid_drv[0]),
    .a_ready   (a_ready),
    .b_beat    (beat_drv[1]),
    .b_valid   (valid_drv[1]),
    .b_ready   (b_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  // handshake seen at the last edge.
  always_ff @(posedge clk) begin
    took_q[0] <= valid_drv[0] & a_ready;
    took_q[1] <= valid_drv[1] & b_ready;
  end

  task automatic build_stimulus();
    narrow_beat_t b;
    int len;
    int gap;
    for (int src = 0; src < num_sources; src++) begin
      for (int p = 0; p < num_packets; p++) begin
        len = 1 + int'($unsigned($random(seed)) % max_len);
        for (int i = 0; i < len; i++) begin
          b.data = byte_w'($random(seed));
          b.last = (i == len - 1);
          b.user = b.last & 1'($random(seed));
          gap = (($random(seed) & 3) == 0) ? int'($unsigned($random(seed)) % 6) : 0;
          stim_q[src].push_back(b);
          gap_q[src].push_back(gap);
          exp_q[src].push_back(b);
        end
      end
    end
  endtask

  task automatic drive_source(input int src);
    narrow_beat_t b;
    int gap;
    while (stim_q[src].size() > 0) begin
      b = stim_q[src].pop_front();
      gap = gap_q[src].pop_front();
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      beat_drv[src] = b;
      valid_drv[src] = 1'b1;
      do begin
        @(posedge clk);
        #1;
      end while (!took_q[src]);
      valid_drv[src] = 1'b0;
    end
  endtask

  task automatic check_beat(input merged_beat_t m);
    narrow_beat_t e;
    logic [byte_w-1:0] got;
    int src;
    int lane;
    src = int'(m.id);
    e = '0;
    beat_cnt++;
    for (lane = 0; lane < wide_bytes; lane++) begin
      if (m.beat.keep[lane]) begin
        got = m.beat.data[lane*byte_w +: byte_w];
        if (exp_q[src].size() == 0) begin
          $display("Source %0d delivered byte %h that was never sent", src, got);
          err_cnt++;
        end else begin
          e = exp_q[src].pop_front();
          if (got !== e.data) begin
            $display("Error: byte_order src%0d lane %0d expected %h actual %h",
                     src, lane, e.data, got);
            err_cnt++;
          end
        end
      end
    end
    if (m.beat.last !== e.last) begin
      $display("Error: last_flag src%0d expected %b actual %b", src, e.last, m.beat.last);
      err_cnt++;
    end
    if (m.beat.user !== e.user) begin
      $display("Error: user_flag src%0d expected %b actual %b", src, e.user, m.beat.user);
      err_cnt++;
    end
  endtask

  always @(posedge clk) begin
    if (!rst && out_valid && out_ready) begin
      check_beat(out_beat);
    end
  end

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    wait (rst === 1'b0);
    forever begin
      @(posedge clk);
      #1;
      out_ready = (($random(seed) & 3) != 0);  // mostly ready.
    end
  end

  initial begin
    #(limit_ns);
    $display("Timeout after %0d ns, not all sent bytes reached the output", limit_ns);
    $display("errors: scoreboard %0d, assertions %0d", err_cnt,
             dual_upsize_merge_i.merge_assert_i.fail_cnt);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    seed = 32'h22a1_a106;
    err_cnt = 0;
    beat_cnt = 0;
    rst = 1'b1;
    out_ready = 1'b0;
    for (int s = 0; s < num_sources; s++) begin
      valid_drv[s] = 1'b0;
      beat_drv[s] = '0;
    end
    build_stimulus();
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    fork
      drive_source(0);
      drive_source(1);
    join
    while (exp_q[0].size() > 0 || exp_q[1].size() > 0) begin
      @(posedge clk);
    end
    repeat (20) @(posedge clk);  // catch duplicated beats.
    $display("errors: scoreboard %0d, assertions %0d, beats checked %0d", err_cnt,
             dual_upsize_merge_i.merge_assert_i.fail_cnt, beat_cnt);
    if (err_cnt == 0 && dual_upsize_merge_i.merge_assert_i.fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verif/merge_assert.sv ====
module merge_assert (
  input logic                    clk,
  input logic                    rst,
  input stream_pkg::wide_beat_t  wa_beat,
  input logic                    wa_valid,
  input logic                    wa_ready,
  input stream_pkg::wide_beat_t  wb_beat,
  input logic                    wb_valid,
  input logic                    wb_ready,
  input merge_pkg::merged_beat_t out_beat,
  input logic                    out_valid,
  input logic                    out_ready
);
  timeunit 1ns;
  timeprecision 100ps;
  import merge_pkg::*;

  logic        out_xfer;
  logic        wa_xfer;
  logic        wb_xfer;
  logic        mid_pkt_q;  // output is inside a packet.
  src_id_t     pkt_id_q;
  logic        want_a_q;
  logic        want_b_q;
  int unsigned fail_cnt = 0;

  assign out_xfer = out_valid & out_ready;
  assign wa_xfer  = wa_valid & wa_ready;
  assign wb_xfer  = wb_valid & wb_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      mid_pkt_q <= 1'b0;
      pkt_id_q  <= '0;
      want_a_q  <= 1'b0;
      want_b_q  <= 1'b0;
    end else begin
      if (out_xfer) begin
        mid_pkt_q <= ~out_beat.beat.last;
        pkt_id_q  <= out_beat.id;
      end
      // other source was already waiting when this packet closed.
      if (wa_xfer && wa_beat.last && wb_valid) begin
        want_b_q <= 1'b1;
      end else if (wb_xfer) begin
        want_b_q <= 1'b0;
      end
      if (wb_xfer && wb_beat.last && wa_valid) begin
        want_a_q <= 1'b1;
      end else if (wa_xfer) begin
        want_a_q <= 1'b0;
      end
    end
  end

  hold_while_stalled: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else begin
      $error("output beat changed while stalled");
      fail_cnt++;
    end

  full_keep_mid_packet: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_beat.beat.last |-> &out_beat.beat.keep)
    else begin
      $error("beat before last is not full");
      fail_cnt++;
    end

  packed_keep_on_last: assert property (@(posedge clk) disable iff (rst)
      out_valid && out_beat.beat.last |->
      out_beat.beat.keep inside {4'b0001, 4'b0011, 4'b0111, 4'b1111})
    else begin
      $error("last beat keep is not packed from lane 0");
      fail_cnt++;
    end

  same_id_in_packet: assert property (@(posedge clk) disable iff (rst)
      out_valid && mid_pkt_q |-> out_beat.id == pkt_id_q)
    else begin
      $error("source id changed inside a packet");
      fail_cnt++;
    end

  turn_goes_to_b: assert property (@(posedge clk) disable iff (rst)
      !(want_b_q && wa_xfer))
    else begin
      $error("source a served twice while b waited");
      fail_cnt++;
    end

  turn_goes_to_a: assert property (@(posedge clk) disable iff (rst)
      !(want_a_q && wb_xfer))
    else begin
      $error("source b served twice while a waited");
      fail_cnt++;
    end

endmodule

bind dual_upsize_merge merge_assert merge_assert_i (
  .clk       (clk),
  .rst       (rst),
  .wa_beat   (wa_beat),
  .wa_valid  (wa_valid),
  .wa_ready  (wa_ready),
  .wb_beat   (wb_beat),
  .wb_valid  (wb_valid),
  .wb_ready  (wb_ready),
  .out_beat  (out_beat),
  .out_valid (out_valid),
  .out_ready (out_ready)
);

// ==== src/dual_upsize_merge.sv ====
module dual_upsize_merge (
  input  logic                     clk,
  input  logic                     rst,
  input  stream_pkg::narrow_beat_t a_beat,
  input  logic                     a_valid,
  output logic                     a_ready,
  input  stream_pkg::narrow_beat_t b_beat,
  input  logic                     b_valid,
  output logic                     b_ready,
  output merge_pkg::merged_beat_t  out_beat,
  output logic                     out_valid,
  input  logic                     out_ready
);
  import stream_pkg::*;

  // wide links between the upsizers and the merger.
  wide_beat_t wa_beat;
  logic       wa_valid;
  logic       wa_ready;
  wide_beat_t wb_beat;
  logic       wb_valid;
  logic       wb_ready;

  axis_upsizer u_a (
    .clk       (clk),
    .rst       (rst),
    .in_beat   (a_beat),
    .in_valid  (a_valid),
    .in_ready  (a_ready),
    .out_beat  (wa_beat),
    .out_valid (wa_valid),
    .out_ready (wa_ready)
  );

  axis_upsizer u_b (
    .clk       (clk),
    .rst       (rst),
    .in_beat   (b_beat),
    .in_valid  (b_valid),
    .in_ready  (b_ready),
    .out_beat  (wb_beat),
    .out_valid (wb_valid),
    .out_ready (wb_ready)
  );

  packet_merge u_merge (
    .clk       (clk),
    .rst       (rst),
    .wa_beat   (wa_beat),
    .wa_valid  (wa_valid),
    .wa_ready  (wa_ready),
    .wb_beat   (wb_beat),
    .wb_valid  (wb_valid),
    .wb_ready  (wb_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

// ==== src/packet_merge.sv ====
module packet_merge (
  input  logic                     clk,
  input  logic                     rst,
  input  stream_pkg::wide_beat_t   wa_beat,
  input  logic                     wa_valid,
  output logic                     wa_ready,
  input  stream_pkg::wide_beat_t   wb_beat,
  input  logic                     wb_valid,
  output logic                     wb_ready,
  output merge_pkg::merged_beat_t  out_beat,
  output logic                     out_valid,
  input  logic                     out_ready
);
  import stream_pkg::*;
  import merge_pkg::*;

  wide_beat_t             beats [num_sources];
  logic [num_sources-1:0] req;
  logic                   lock_q;    // a packet is in flight.
  src_id_t                grant_q;
  src_id_t                last_q;    // source served last.
  src_id_t                pick;
  logic                   in_open_q;
  logic                   xfer;
  logic                   out_take;
  merged_beat_t           merged_d;
  merged_beat_t           out_q;
  logic                   out_valid_q;
  merged_beat_t           skid_q;
  logic                   skid_valid_q;
  logic                   skid_valid_d;

  assign beats[0] = wa_beat;
  assign beats[1] = wb_beat;
  assign req      = {wb_valid, wa_valid};

  // other source first, else whoever asks.
  assign pick = req[~last_q] ? ~last_q : last_q;

  assign wa_ready = lock_q & in_open_q & (grant_q == src_id_t'(0));
  assign wb_ready = lock_q & in_open_q & (grant_q == src_id_t'(1));

  assign xfer     = lock_q & in_open_q & req[grant_q];
  assign out_take = out_ready | ~out_valid_q;

  assign merged_d.beat = beats[grant_q];
  assign merged_d.id   = grant_q;

  assign out_beat  = out_q;
  assign out_valid = out_valid_q;

  always_comb begin
    skid_valid_d = skid_valid_q;
    if (out_take) begin
      skid_valid_d = 1'b0;
    end else if (xfer) begin
      skid_valid_d = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lock_q       <= 1'b0;
      grant_q      <= '0;
      last_q       <= '1;
      in_open_q    <= 1'b0;
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else begin
      in_open_q    <= ~skid_valid_d;
      skid_valid_q <= skid_valid_d;
      if (out_take) begin
        out_valid_q <= skid_valid_q | xfer;
      end
      if (xfer && merged_d.beat.last) begin
        lock_q <= 1'b0;  // release after the last beat.
      end else if (!lock_q && |req) begin
        lock_q  <= 1'b1;
        grant_q <= pick;
        last_q  <= pick;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (out_take) begin
      if (skid_valid_q) begin
        out_q <= skid_q;
      end else if (xfer) begin
        out_q <= merged_d;
      end
    end else if (xfer) begin
      skid_q <= merged_d;
    end
  end

endmodule

// ==== src/axis_upsizer.sv ====
module axis_upsizer (
  input  logic                     clk,
  input  logic                     rst,
  input  stream_pkg::narrow_beat_t in_beat,
  input  logic                     in_valid,
  output logic                     in_ready,
  output stream_pkg::wide_beat_t   out_beat,
  output logic                     out_valid,
  input  logic                     out_ready
);
  import stream_pkg::*;

  localparam int lane_w = $clog2(wide_bytes);
  localparam logic [lane_w-1:0] last_lane = lane_w'(wide_bytes - 1);

  // collect fills lanes, emit waits on a full skid register.
  typedef enum logic {
    st_collect,
    st_emit
  } state_t;

  state_t            state_q;
  state_t            state_d;
  logic              in_ready_q;
  logic [lane_w-1:0] lane_q;
  wide_beat_t        stage_q;   // partial word being filled.
  wide_beat_t        word_d;
  wide_beat_t        out_q;
  logic              out_valid_q;
  wide_beat_t        skid_q;
  logic              accept;
  logic              closing;
  logic              out_take;

  assign in_ready  = in_ready_q;
  assign out_beat  = out_q;
  assign out_valid = out_valid_q;

  assign accept   = in_valid & in_ready_q;
  assign closing  = accept & ((lane_q == last_lane) | in_beat.last);
  assign out_take = out_ready | ~out_valid_q;

  // staging word with the incoming byte merged into its lane.
  always_comb begin
    word_d = stage_q;
    if (lane_q == '0) begin
      word_d.data = '0;
      word_d.keep = '0;
    end
    word_d.data[lane_q*byte_w +: byte_w] = in_beat.data;
    word_d.keep[lane_q] = 1'b1;
    word_d.last = in_beat.last;
    word_d.user = in_beat.user;
  end

  always_comb begin
    state_d = state_q;
    if (out_take && state_q == st_emit) begin
      state_d = st_collect;  // skid drains into the output.
    end else if (!out_take && closing) begin
      state_d = st_emit;     // output busy, park the word.
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= st_collect;
      in_ready_q  <= 1'b0;
      lane_q      <= '0;
      out_valid_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      in_ready_q <= (state_d == st_collect);
      if (accept) begin
        lane_q <= closing ? '0 : lane_q + 1'b1;
      end
      if (out_take) begin
        out_valid_q <= (state_q == st_emit) | closing;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && !closing) begin
      stage_q <= word_d;
    end
    if (out_take) begin
      if (state_q == st_emit) begin
        out_q <= skid_q;
      end else if (closing) begin
        out_q <= word_d;  // bypass straight to the output.
      end
    end else if (closing) begin
      skid_q <= word_d;
    end
  end

endmodule

// ==== src/merge_pkg.sv ====
package merge_pkg;

  localparam int num_sources = 2;

  typedef logic [$clog2(num_sources)-1:0] src_id_t;

  // wide beat tagged with the source it came from.
  typedef struct packed {
    stream_pkg::wide_beat_t beat;
    src_id_t                id;
  } merged_beat_t;

endpackage

// ==== src/stream_pkg.sv ====
package stream_pkg;

  // lane geometry of the wide side.
  localparam int byte_w = 8;
  localparam int wide_bytes = 4;

  // one byte per beat on the receive side.
  typedef struct packed {
    logic [byte_w-1:0] data;
    logic              last;
    logic              user;
  } narrow_beat_t;

  // packed word, lanes filled from the low byte up.
  typedef struct packed {
    logic [wide_bytes*byte_w-1:0] data;
    logic [wide_bytes-1:0]        keep;  // one bit per filled lane.
    logic                         last;
    logic                         user;  // taken from the final byte.
  } wide_beat_t;

endpackage
